//--- design/bridgePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the host to bus command bridge: words, counts,
// block address, command codes and the parsed frame header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package bridgePkg;

	typedef logic [15:0] word_t;   // one word on host or bus link
	typedef logic [15:0] count_t;  // word count or fill level
	typedef logic [7:0]  addr_t;   // upper byte of a header word

	// command code, lower byte of a header word
	typedef enum logic [7:0] {
		cmdUnknown    = 8'h00,
		cmdReset      = 8'h01,
		cmdSendData   = 8'h02,
		cmdReadStatus = 8'h03,
		cmdReadData   = 8'h04
	} cmd_e;

	typedef struct packed {
		addr_t  addr;
		cmd_e   cmd;
		count_t size;
	} frameHdr_t;

	localparam int STATUS_WORDS = 2;  // rx fill level, then tx fill level

	// unlisted codes fold into cmdUnknown
	function automatic cmd_e decodeCmd(input logic [7:0] code);
		cmd_e result;
		case (code)
			8'h01:   result = cmdReset;
			8'h02:   result = cmdSendData;
			8'h03:   result = cmdReadStatus;
			8'h04:   result = cmdReadData;
			default: result = cmdUnknown;
		endcase
		return result;
	endfunction

endpackage

`default_nettype wire

//--- design/wordFifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous word buffer with a fill count, valid/ready on both sides
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module wordFifo import bridgePkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   pushValid,
	input  word_t  pushData,
	output logic   pushReady,
	output logic   popValid,
	output word_t  popData,
	input  logic   popTake,
	output count_t used
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	word_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic             doPush;
	logic             doPop;

	assign pushReady = (used < count_t'(FIFO_DEPTH));
	assign popValid  = (used != '0);
	assign popData   = mem[rdPtr];

	assign doPush = pushValid && pushReady;
	assign doPop  = popTake && popValid;

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			used  <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop)
				used <= used + 1'b1;
			else if (doPop && !doPush)
				used <= used - 1'b1;
		end
	end

	// storage, written only on an accepted push
	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// consumer must not take from an empty buffer
	assert property (@(posedge clk) disable iff (rst) popTake |-> popValid);

	// a push refused on a full buffer is offered again with the same word
	assert property (@(posedge clk) disable iff (rst)
		(pushValid && !pushReady) |=> (pushValid && $stable(pushData)));

endmodule

`default_nettype wire

//--- design/hostPort.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host link receiver: takes frames word by word over req/ack, hands the
// header to the command unit and routes send-data payload to the tx FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module hostPort import bridgePkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      hostReq,
	input  word_t     hostWord,
	output logic      hostAck,
	output frameHdr_t hdr,
	output logic      hdrValid,
	input  logic      payloadKeep,
	input  logic      frameDone,
	output logic      txPushValid,
	output word_t     txPushData,
	input  logic      txPushReady
);

	typedef enum logic [1:0] {
		stHeader,
		stSize,
		stPayload,
		stWaitDone
	} hpState_e;

	hpState_e state;
	count_t   remaining;   // payload words still to come
	logic     hdrPending;  // size taken, header goes out next cycle
	logic     doneSeen;    // frameDone came while payload still running
	logic     canTake;
	logic     accept;

	// payload that is kept needs room downstream, dropped payload does not
	always_comb begin
		case (state)
			stHeader:  canTake = 1'b1;
			stSize:    canTake = 1'b1;
			stPayload: canTake = !payloadKeep || txPushReady;
			default:   canTake = 1'b0;
		endcase
	end

	assign accept = hostReq && !hostAck && canTake;

	assign txPushValid = (state == stPayload) && hostReq && !hostAck && payloadKeep;
	assign txPushData  = hostWord;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= stHeader;
			hostAck    <= 1'b0;
			hdrValid   <= 1'b0;
			hdrPending <= 1'b0;
			doneSeen   <= 1'b0;
			remaining  <= '0;
		end else begin
			hdrPending <= accept && (state == stSize);
			hdrValid   <= hdrPending;

			if (accept)
				hostAck <= 1'b1;
			else if (hostAck && !hostReq)
				hostAck <= 1'b0;  // req seen low, close the handshake

			if (frameDone)
				doneSeen <= 1'b1;

			case (state)
				stHeader: if (accept) state <= stSize;
				stSize: if (accept) begin
					remaining <= count_t'(hostWord);
					if (hdr.cmd == cmdSendData && hostWord != '0)
						state <= stPayload;
					else
						state <= stWaitDone;
				end
				stPayload: if (accept) begin
					remaining <= remaining - 1'b1;
					if (remaining == count_t'(1))
						state <= stWaitDone;
				end
				stWaitDone: if (doneSeen || frameDone) begin
					doneSeen <= 1'b0;
					state    <= stHeader;
				end
				default: state <= stHeader;
			endcase
		end
	end

	// header fields are held until the next frame overwrites them
	always_ff @(posedge clk) begin
		if (accept && state == stHeader) begin
			hdr.addr <= addr_t'(hostWord[15:8]);
			hdr.cmd  <= decodeCmd(hostWord[7:0]);
		end
		if (accept && state == stSize)
			hdr.size <= count_t'(hostWord);
	end

	// host keeps the word steady until it is acknowledged
	assert property (@(posedge clk) disable iff (rst)
		(hostReq && !hostAck) ##1 (hostReq && !hostAck) |-> $stable(hostWord));

endmodule

`default_nettype wire

//--- design/busPort.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus side: sends tx FIFO words out over req/ack and stores incoming
// bus words in the rx FIFO, one handshake at a time per direction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module busPort import bridgePkg::*; (
	input  logic  clk,
	input  logic  rst,
	output logic  busOutReq,
	output word_t busOutWord,
	input  logic  busOutAck,
	input  logic  busInReq,
	input  word_t busInWord,
	output logic  busInAck,
	input  logic  txPopValid,
	input  word_t txPopData,
	output logic  txPopTake,
	output logic  rxPushValid,
	output word_t rxPushData,
	input  logic  rxPushReady
);

	typedef enum logic {txIdle, txActive} txState_e;
	typedef enum logic {rxIdle, rxAcked} rxState_e;

	txState_e txState;
	rxState_e rxState;

	// word leaves the tx FIFO only once the sink has taken it
	assign txPopTake  = (txState == txActive) && busOutAck;
	assign busOutReq  = (txState == txActive);
	assign busOutWord = txPopData;  // FIFO head, held until popped

	always_ff @(posedge clk) begin
		if (rst) begin
			txState <= txIdle;
		end else begin
			case (txState)
				txIdle:   if (txPopValid && !busOutAck) txState <= txActive;  // ack low first
				txActive: if (busOutAck) txState <= txIdle;  // drop req
				default:  txState <= txIdle;
			endcase
		end
	end

	// word lands in the rx FIFO on the same edge ack goes up
	assign rxPushValid = (rxState == rxIdle) && busInReq;
	assign rxPushData  = busInWord;
	assign busInAck    = (rxState == rxAcked);

	always_ff @(posedge clk) begin
		if (rst) begin
			rxState <= rxIdle;
		end else begin
			case (rxState)
				rxIdle:  if (rxPushValid && rxPushReady) rxState <= rxAcked;
				rxAcked: if (!busInReq) rxState <= rxIdle;
				default: rxState <= rxIdle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		busOutReq ##1 busOutReq |-> $stable(busOutWord));

endmodule

`default_nettype wire

//--- design/commandUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame decode and reply: filters on block address, snapshots status,
// returns status or rx words to the host, raises the reset request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module commandUnit import bridgePkg::*; #(
	parameter addr_t BLOCK_ADDR = 8'hAB
) (
	input  logic      clk,
	input  logic      rst,
	input  frameHdr_t hdr,
	input  logic      hdrValid,
	output logic      payloadKeep,
	output logic      frameDone,
	input  logic      rxPopValid,
	input  word_t     rxPopData,
	output logic      rxPopTake,
	input  count_t    rxUsed,
	input  count_t    txUsed,
	output logic      replyReq,
	output word_t     replyWord,
	input  logic      replyAck,
	output logic      resetRequest
);

	typedef enum logic [1:0] {cuIdle, cuLength, cuNext, cuSend} cuState_e;

	cuState_e state;
	cmd_e     cmdReg;
	count_t   sizeReg;
	count_t   remaining;              // reply words left
	count_t   snap [STATUS_WORDS];    // status snapshot, rx first
	logic     addrMatch;
	cmd_e     effCmd;
	logic     sendWord;

	assign addrMatch   = (hdr.addr == BLOCK_ADDR);
	assign effCmd      = addrMatch ? hdr.cmd : cmdUnknown;  // foreign frames do nothing
	assign payloadKeep = addrMatch && (hdr.cmd == cmdSendData);

	// start a reply word once the host has dropped the previous ack
	assign sendWord = (state == cuNext) && !replyAck && (remaining != '0)
		&& ((cmdReg != cmdReadData) || rxPopValid);
	assign rxPopTake = sendWord && (cmdReg == cmdReadData);

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= cuIdle;
			cmdReg       <= cmdUnknown;
			remaining    <= '0;
			replyReq     <= 1'b0;
			frameDone    <= 1'b0;
			resetRequest <= 1'b0;
		end else begin
			frameDone <= 1'b0;
			case (state)
				cuIdle: if (hdrValid) begin
					cmdReg <= effCmd;
					state  <= cuLength;
				end
				cuLength: begin
					case (cmdReg)
						cmdReadStatus: remaining <= count_t'(STATUS_WORDS);
						cmdReadData:   remaining <= (sizeReg < snap[0]) ? sizeReg : snap[0];
						default:       remaining <= '0;
					endcase
					if (cmdReg == cmdReset)
						resetRequest <= 1'b1;  // sticky until rst
					state <= cuNext;
				end
				cuNext: begin
					if (sendWord) begin
						replyReq <= 1'b1;
						state    <= cuSend;
					end else if (!replyAck && remaining == '0) begin
						frameDone <= 1'b1;
						state     <= cuIdle;
					end
				end
				cuSend: if (replyAck) begin
					replyReq  <= 1'b0;
					remaining <= remaining - 1'b1;
					state     <= cuNext;
				end
				default: state <= cuIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cuIdle && hdrValid) begin
			sizeReg <= hdr.size;
			snap[0] <= rxUsed;
			snap[1] <= txUsed;
		end
		if (sendWord) begin
			replyWord <= (cmdReg == cmdReadData) ? rxPopData : word_t'(snap[0]);
			if (cmdReg == cmdReadStatus) begin
				for (int i = 0; i < STATUS_WORDS - 1; i++)
					snap[i] <= snap[i + 1];  // next status word to the front
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(replyReq && !replyAck) ##1 (replyReq && !replyAck) |-> $stable(replyWord));

endmodule

`default_nettype wire

//--- design/bridgeTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bridge top level: host port, bus port, command unit and two FIFOs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module bridgeTop import bridgePkg::*; #(
	parameter int    FIFO_DEPTH = 16,
	parameter addr_t BLOCK_ADDR = 8'hAB
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  hostReq,
	input  word_t hostWord,
	output logic  hostAck,
	output logic  replyReq,
	output word_t replyWord,
	input  logic  replyAck,
	input  logic  busInReq,
	input  word_t busInWord,
	output logic  busInAck,
	output logic  busOutReq,
	output word_t busOutWord,
	input  logic  busOutAck,
	output logic  resetRequest
);

	frameHdr_t hdr;
	logic      hdrValid;
	logic      payloadKeep;
	logic      frameDone;

	logic      txPushValid, txPushReady, txPopValid, txPopTake;
	word_t     txPushData, txPopData;
	count_t    txUsed;

	logic      rxPushValid, rxPushReady, rxPopValid, rxPopTake;
	word_t     rxPushData, rxPopData;
	count_t    rxUsed;

	hostPort i_hostPort (
		.clk, .rst,
		.hostReq, .hostWord, .hostAck,
		.hdr, .hdrValid, .payloadKeep, .frameDone,
		.txPushValid, .txPushData, .txPushReady
	);

	// host to bus
	wordFifo #(.FIFO_DEPTH(FIFO_DEPTH)) txFifo (
		.clk, .rst,
		.pushValid(txPushValid), .pushData(txPushData), .pushReady(txPushReady),
		.popValid(txPopValid), .popData(txPopData), .popTake(txPopTake),
		.used(txUsed)
	);

	busPort i_busPort (
		.clk, .rst,
		.busOutReq, .busOutWord, .busOutAck,
		.busInReq, .busInWord, .busInAck,
		.txPopValid, .txPopData, .txPopTake,
		.rxPushValid, .rxPushData, .rxPushReady
	);

	// bus to host
	wordFifo #(.FIFO_DEPTH(FIFO_DEPTH)) rxFifo (
		.clk, .rst,
		.pushValid(rxPushValid), .pushData(rxPushData), .pushReady(rxPushReady),
		.popValid(rxPopValid), .popData(rxPopData), .popTake(rxPopTake),
		.used(rxUsed)
	);

	commandUnit #(.BLOCK_ADDR(BLOCK_ADDR)) i_commandUnit (
		.clk, .rst,
		.hdr, .hdrValid, .payloadKeep, .frameDone,
		.rxPopValid, .rxPopData, .rxPopTake,
		.rxUsed, .txUsed,
		.replyReq, .replyWord, .replyAck,
		.resetRequest
	);

endmodule

`default_nettype wire

//--- verification/bridgeTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the command bridge: host, reply and bus channel models,
// reference queues and one result line per test, run with bridgeTb on top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module bridgeTb import bridgePkg::*; ();

	localparam int    FIFO_DEPTH  = 16;
	localparam addr_t BLOCK_ADDR  = 8'hAB;
	// upper word counts of the six tests, in run order
	localparam int    TOTAL_WORDS = 80 + 20 + 40 + 40 + 60 + 10;
	localparam int    WORD_CYCLES = 40;

	logic  clk = 1'b0;
	logic  rst, hostReq, hostAck, replyReq, replyAck;
	logic  busInReq, busInAck, busOutReq, busOutAck, resetRequest;
	word_t hostWord, replyWord, busInWord, busOutWord;

	integer seed = 32'hd6ee1aea;
	int     errCount = 0;
	int     errBase = 0;
	int     passCount = 0;
	int     failCount = 0;
	logic   sinkPaused = 1'b0;
	word_t  payload[$];   // host payload still to send
	word_t  expBus[$];    // expected on busOut
	word_t  busQ[$];      // seen on busOut
	word_t  rxModel[$];   // bus words buffered in the bridge
	word_t  expReply[$];
	word_t  replyQ[$];

	bridgeTop #(.FIFO_DEPTH(FIFO_DEPTH), .BLOCK_ADDR(BLOCK_ADDR)) i_bridgeTop (
		.clk, .rst,
		.hostReq, .hostWord, .hostAck,
		.replyReq, .replyWord, .replyAck,
		.busInReq, .busInWord, .busInAck,
		.busOutReq, .busOutWord, .busOutAck,
		.resetRequest
	);

	always #4 clk = ~clk;

	// all driving and sampling happens 1 unit after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic hostSend(input word_t w);
		hostWord = w;
		hostReq  = 1'b1;
		do tick(); while (!hostAck);
		hostReq = 1'b0;
		do tick(); while (hostAck);
	endtask

	task automatic busInject(input word_t w);
		busInWord = w;
		busInReq  = 1'b1;
		do tick(); while (!busInAck);
		busInReq = 1'b0;
		do tick(); while (busInAck);
	endtask

	// header, size, then payload for send-data only
	task automatic sendFrame(input addr_t addr, input logic [7:0] code, input int size);
		hostSend({addr, code});
		hostSend(word_t'(size));
		if (code == cmdSendData) begin
			repeat (size) hostSend(payload.pop_front());
		end
	endtask

	task automatic queuePayload(input int n, input bit keep);
		word_t w;
		repeat (n) begin
			w = word_t'($random(seed));
			payload.push_back(w);
			if (keep)
				expBus.push_back(w);  // kept payload reaches the bus in order
		end
	endtask

	task automatic injectRandom(input int n);
		word_t w;
		repeat (n) begin
			w = word_t'($random(seed));
			rxModel.push_back(w);
			busInject(w);
		end
	endtask

	// a read returns the smaller of size and what is buffered
	task automatic readFrame(input int size);
		int n;
		n = (size < rxModel.size()) ? size : rxModel.size();
		repeat (n) expReply.push_back(rxModel.pop_front());
		sendFrame(BLOCK_ADDR, cmdReadData, size);
	endtask

	task automatic waitWords(input bit onBus);
		while ((onBus ? busQ.size() : replyQ.size()) < (onBus ? expBus.size() : expReply.size()))
			tick();
		repeat (20) tick();  // room for a stray extra word
	endtask

	task automatic reportMismatch(input string name, input int expVal, input int actVal);
		$display("MISMATCH %s: expected %0h, actual %0h", name, expVal, actVal);
		errCount++;
	endtask

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		errCount++;
	endtask

	task automatic checkWords(input string name, input bit onBus);
		word_t exp[$];
		word_t got[$];
		if (onBus) begin
			exp = expBus;
			got = busQ;
			expBus.delete();
			busQ.delete();
		end else begin
			exp = expReply;
			got = replyQ;
			expReply.delete();
			replyQ.delete();
		end
		if (got.size() != exp.size())
			reportMismatch({name, " word count"}, exp.size(), got.size());
		for (int i = 0; i < exp.size() && i < got.size(); i++) begin
			if (got[i] !== exp[i])
				reportMismatch($sformatf("%s word %0d", name, i), int'(exp[i]), int'(got[i]));
		end
	endtask

	task automatic finishTest(input string name);
		if (errCount == errBase) begin
			passCount++;
			$display("test %s: pass", name);
		end else begin
			failCount++;
			$display("test %s: fail with %0d errors", name, errCount - errBase);
		end
		errBase = errCount;
	endtask

	// reply receiver, takes every word the bridge offers
	initial begin
		replyAck = 1'b0;
		forever begin
			tick();
			if (replyReq && !replyAck) begin
				replyQ.push_back(replyWord);
				replyAck = 1'b1;
			end else if (!replyReq && replyAck) begin
				replyAck = 1'b0;
			end
		end
	end

	// bus sink with a random ack delay of 0 to 5 cycles
	initial begin
		int delay;
		busOutAck = 1'b0;
		forever begin
			tick();
			if (busOutReq && !busOutAck && !sinkPaused) begin
				delay = $unsigned($random(seed)) % 6;
				repeat (delay) tick();
				busQ.push_back(busOutWord);
				busOutAck = 1'b1;
			end else if (!busOutReq && busOutAck) begin
				busOutAck = 1'b0;
			end
		end
	end

	initial begin
		repeat (TOTAL_WORDS * WORD_CYCLES) @(posedge clk);
		$display("watchdog: run hung, not done after %0d cycles", TOTAL_WORDS * WORD_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int    n;
		int    m;
		addr_t addr;
		rst       = 1'b1;
		hostReq   = 1'b0;
		hostWord  = '0;
		busInReq  = 1'b0;
		busInWord = '0;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
		tick();

		repeat (8) begin
			n = 1 + $unsigned($random(seed)) % 8;
			queuePayload(n, 1'b1);
			sendFrame(BLOCK_ADDR, cmdSendData, n);
		end
		waitWords(1'b1);
		checkWords("sendData", 1'b1);
		finishTest("sendData");

		injectRandom(2);  // must survive the foreign read
		for (int c = 0; c < 6; c++) begin
			addr = addr_t'($random(seed));
			if (addr == BLOCK_ADDR)
				addr = ~BLOCK_ADDR;
			if (c == 2)
				queuePayload(3, 1'b0);
			sendFrame(addr, 8'(c), (c == 2) ? 3 : 4);
		end
		repeat (30) tick();
		if (replyQ.size() != 0)
			reportMismatch("foreignAddress reply words", 0, replyQ.size());
		if (busQ.size() != 0 || busOutReq)
			reportFailure("foreignAddress: bus output became active");
		if (resetRequest)
			reportMismatch("foreignAddress resetRequest", 0, 1);
		readFrame(2);
		waitWords(1'b0);
		checkWords("foreignAddress", 1'b0);
		finishTest("foreignAddress");

		injectRandom(4 + $unsigned($random(seed)) % 9);
		while (rxModel.size() > 0)
			readFrame(1 + $unsigned($random(seed)) % 6);
		readFrame(3);  // empty buffer, empty reply
		waitWords(1'b0);
		checkWords("readData", 1'b0);
		finishTest("readData");

		sinkPaused = 1'b1;
		n = 1 + $unsigned($random(seed)) % 16;
		m = $unsigned($random(seed)) % 17;
		queuePayload(n, 1'b1);
		sendFrame(BLOCK_ADDR, cmdSendData, n);
		injectRandom(m);
		expReply.push_back(word_t'(m));
		expReply.push_back(word_t'(n));
		sendFrame(BLOCK_ADDR, cmdReadStatus, 0);
		readFrame(16);
		waitWords(1'b0);
		checkWords("readStatus", 1'b0);
		sinkPaused = 1'b0;
		waitWords(1'b1);
		checkWords("readStatus", 1'b1);
		finishTest("readStatus");

		fork
			injectRandom(20);
			begin
				repeat (100) tick();
				if (!(busInReq && !busInAck))
					reportFailure("backPressure: busInAck did not stall on a full buffer");
				while (replyQ.size() < 20)
					sendFrame(BLOCK_ADDR, cmdReadData, 8);
			end
		join
		while (rxModel.size() > 0)
			expReply.push_back(rxModel.pop_front());
		waitWords(1'b0);
		checkWords("backPressure", 1'b0);
		sinkPaused = 1'b1;
		queuePayload(20, 1'b1);
		fork
			sendFrame(BLOCK_ADDR, cmdSendData, 20);
			begin
				repeat (120) tick();
				if (!(hostReq && !hostAck))
					reportFailure("backPressure: hostAck did not stall on a full buffer");
				sinkPaused = 1'b0;
			end
		join
		waitWords(1'b1);
		checkWords("backPressure", 1'b1);
		finishTest("backPressure");

		sendFrame(BLOCK_ADDR, 8'h3C, 0);
		repeat (10) tick();
		if (resetRequest)
			reportMismatch("resetCommand unknown code", 0, 1);
		sendFrame(BLOCK_ADDR, cmdReset, 0);
		repeat (10) tick();
		if (!resetRequest)
			reportMismatch("resetCommand after reset frame", 1, 0);
		repeat (40) tick();
		if (!resetRequest)
			reportMismatch("resetCommand held", 1, 0);
		checkWords("resetCommand", 1'b0);
		rst = 1'b1;
		repeat (5) tick();
		rst = 1'b0;
		tick();
		if (resetRequest || hostAck || replyReq || busOutReq || busInAck)
			reportFailure("resetCommand: outputs not all low after rst");
		finishTest("resetCommand");

		$display("summary: %0d tests passed, %0d failed, %0d errors", passCount, failCount,
			errCount);
		if (errCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
design/bridgePkg.sv
design/wordFifo.sv
design/hostPort.sv
design/busPort.sv
design/commandUnit.sv
design/bridgeTop.sv
verification/bridgeTb.sv

//--- Bender.yml
package:
  name: bridge

sources:
  - design/bridgePkg.sv
  - design/wordFifo.sv
  - design/hostPort.sv
  - design/busPort.sv
  - design/commandUnit.sv
  - design/bridgeTop.sv
  - target: test
    files:
      - verification/bridgeTb.sv
